//--- hdl/alu_defs.svh
// Width and depth macros shared by the integer execute unit
// Included by the package and by the datapath blocks that size registers

`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// ========================================
// Datapath widths
// ========================================

// Operand and result word width
`define ALU_WIDTH 64

// Shift amount is taken from the low bits of c
`define ALU_SHAMT_WIDTH 6

// ========================================
// Multi-cycle unit sizing
// ========================================

// Number of registered stages in the multiplier pipeline
`define ALU_MUL_STAGES 3

// Iteration counter of the divider, wide enough to hold the word width
`define ALU_DIV_CNT_WIDTH 7

`endif

//--- hdl/alu_pkg.sv
// Types shared across the integer execute unit
// Modules name these in their port lists and import the package in the body

`include "alu_defs.svh"

package alu_pkg;

	// ========================================
	// Data words
	// ========================================

	// One operand or one result
	typedef logic [`ALU_WIDTH-1:0] value_t;

	// Full product of two words
	typedef logic [2*`ALU_WIDTH-1:0] double_value_t;

	// ========================================
	// Operation encoding
	// ========================================

	// Major opcode, OP_R2 picks its function from func
	typedef enum logic [3:0] {
		OP_R2    = 4'd0,
		OP_ADDI  = 4'd1,
		OP_ANDI  = 4'd2,
		OP_ORI   = 4'd3,
		OP_EORI  = 4'd4,
		OP_SLTI  = 4'd5,
		OP_MULI  = 4'd6,
		OP_DIVI  = 4'd7,
		OP_SHIFT = 4'd8,
		OP_MOV   = 4'd9
	} opcode_t;

	// Register-register function codes
	// Under OP_SHIFT only the low two bits count: 0 is ASL, 1 is LSR, 2 is ASR
	// Immediate opcodes should carry FN_ADD here, the multiplier picks imm
	// over b whenever func is not one of the four multiply functions
	typedef enum logic [4:0] {
		FN_ADD   = 5'd0,  FN_SUB   = 5'd1,
		FN_AND   = 5'd2,  FN_OR    = 5'd3,  FN_EOR   = 5'd4,  FN_ANDC  = 5'd5,
		FN_NAND  = 5'd6,  FN_NOR   = 5'd7,  FN_ENOR  = 5'd8,  FN_ORC   = 5'd9,
		FN_SEQ   = 5'd10, FN_SNE   = 5'd11, FN_SLT   = 5'd12, FN_SLE   = 5'd13,
		FN_SLTU  = 5'd14, FN_SLEU  = 5'd15,
		FN_MAX3  = 5'd16, FN_MIN3  = 5'd17, FN_MID3  = 5'd18,
		FN_MAXU3 = 5'd19, FN_MINU3 = 5'd20, FN_MIDU3 = 5'd21,
		FN_MUL   = 5'd22, FN_MULU  = 5'd23, FN_MULH  = 5'd24, FN_MULUH = 5'd25,
		FN_DIV   = 5'd26, FN_DIVU  = 5'd27, FN_MOD   = 5'd28, FN_MODU  = 5'd29
	} func_t;

	// Add and sub variant. 0 plain, 2 adds one to an add and takes one from a sub,
	// 3 does the reverse, 1 forces a zero result
	typedef logic [1:0] carry_t;

	// Modifier on c for the logic functions.
	// 0 as is, 1 two's complement, 2 one's complement, 3 sign bit flipped
	typedef logic [1:0] cmod_t;

	// ========================================
	// Control
	// ========================================

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MUL,
		ST_DIV,
		ST_HOLD
	} alu_state_t;

endpackage

//--- hdl/alu_logic.sv
// Single-cycle arithmetic and logic of the execute unit
// Purely combinational, the control block registers the output on accept

`timescale 1ns/1ps

module alu_logic (
	input  alu_pkg::opcode_t op,
	input  alu_pkg::func_t   func,
	input  alu_pkg::carry_t  carry,
	input  alu_pkg::cmod_t   cmod,
	input  alu_pkg::value_t  a,
	input  alu_pkg::value_t  b,
	input  alu_pkg::value_t  c,
	input  alu_pkg::value_t  imm,
	output alu_pkg::value_t  logic_result
);
	import alu_pkg::*;

	// Returned for function codes this unit does not handle
	localparam value_t FILLER = {2{32'hDEADBEEF}};

	value_t cc;
	value_t cy;
	value_t sum3;
	value_t diff3;

	// Less-than in either signedness
	function automatic logic less(input value_t x, input value_t y, input logic sgn);
		less = sgn ? ($signed(x) < $signed(y)) : (x < y);
	endfunction

	function automatic value_t max3(input value_t x, input value_t y, input value_t z,
		input logic sgn);
		value_t m;
		m = less(x, y, sgn) ? y : x;
		max3 = less(m, z, sgn) ? z : m;
	endfunction

	function automatic value_t min3(input value_t x, input value_t y, input value_t z,
		input logic sgn);
		value_t m;
		m = less(y, x, sgn) ? y : x;
		min3 = less(z, m, sgn) ? z : m;
	endfunction

	// Median, z is clamped between the smaller and larger of x and y
	function automatic value_t mid3(input value_t x, input value_t y, input value_t z,
		input logic sgn);
		value_t lo;
		value_t hi;
		lo = less(y, x, sgn) ? y : x;
		hi = less(x, y, sgn) ? y : x;
		if (less(z, lo, sgn))
			mid3 = lo;
		else if (less(hi, z, sgn))
			mid3 = hi;
		else
			mid3 = z;
	endfunction

	// Third operand after the modifier
	always_comb
	begin
		case (cmod)
			2'd0: cc = c;
			2'd1: cc = -c;
			2'd2: cc = ~c;
			default: cc = {~c[$bits(value_t)-1], c[$bits(value_t)-2:0]};
		endcase
	end

	// Carry adjust is added to sums and taken from differences
	always_comb
	begin
		case (carry)
			2'd2: cy = value_t'(1);
			2'd3: cy = '1;
			default: cy = '0;
		endcase
		sum3  = a + b + c + cy;
		diff3 = a - b - c - cy;
	end

	always_comb
	begin
		case (op)
			OP_R2:
			begin
				case (func)
					FN_ADD:   logic_result = (carry == 2'd1) ? '0 : sum3;
					FN_SUB:   logic_result = (carry == 2'd1) ? '0 : diff3;
					FN_AND:   logic_result = a & b & ~cc;
					FN_OR:    logic_result = a | b | cc;
					FN_EOR:   logic_result = a ^ b ^ cc;
					FN_ANDC:  logic_result = a & ~b & ~cc;
					FN_NAND:  logic_result = ~(a & b & ~cc);
					FN_NOR:   logic_result = ~(a | b | cc);
					FN_ENOR:  logic_result = ~(a ^ b ^ cc);
					FN_ORC:   logic_result = a | ~b | cc;
					FN_SEQ:   logic_result = value_t'(a == b);
					FN_SNE:   logic_result = value_t'(a != b);
					FN_SLT:   logic_result = value_t'(less(a, b, 1'b1));
					FN_SLE:   logic_result = value_t'(!less(b, a, 1'b1));
					FN_SLTU:  logic_result = value_t'(less(a, b, 1'b0));
					FN_SLEU:  logic_result = value_t'(!less(b, a, 1'b0));
					FN_MAX3:  logic_result = max3(a, b, c, 1'b1);
					FN_MIN3:  logic_result = min3(a, b, c, 1'b1);
					FN_MID3:  logic_result = mid3(a, b, c, 1'b1);
					FN_MAXU3: logic_result = max3(a, b, c, 1'b0);
					FN_MINU3: logic_result = min3(a, b, c, 1'b0);
					FN_MIDU3: logic_result = mid3(a, b, c, 1'b0);
					// Multiply and divide results come from their own units
					default:  logic_result = FILLER;
				endcase
			end
			OP_ADDI: logic_result = a + imm;
			OP_ANDI: logic_result = a & imm;
			OP_ORI:  logic_result = a | imm;
			OP_EORI: logic_result = a ^ imm;
			OP_SLTI: logic_result = value_t'(less(a, imm, 1'b1));
			OP_MOV:  logic_result = a;
			default: logic_result = FILLER;
		endcase
	end

endmodule

//--- hdl/alu_shift.sv
// Funnel shifter of the execute unit
// The amount is the low bits of c, b sits above a for the funnel shifts

`timescale 1ns/1ps

`include "alu_defs.svh"

module alu_shift (
	input  alu_pkg::func_t  func,
	input  alu_pkg::value_t a,
	input  alu_pkg::value_t b,
	input  alu_pkg::value_t c,
	output alu_pkg::value_t shift_result
);
	import alu_pkg::*;

	logic [`ALU_SHAMT_WIDTH-1:0] amt;
	double_value_t shl;
	double_value_t shr;
	double_value_t sar;

	assign amt = c[`ALU_SHAMT_WIDTH-1:0];

	always_comb
	begin
		shl = {b, a} << amt;
		shr = {b, a} >> amt;
		// Sign copies fill from the top, only a takes part
		sar = {{`ALU_WIDTH{a[`ALU_WIDTH-1]}}, a} >> amt;
	end

	always_comb
	begin
		case (func[1:0])
			// Bits of a enter the bottom of b
			2'd0: shift_result = shl[2*`ALU_WIDTH-1:`ALU_WIDTH];
			// Bits of b enter the top of a
			2'd1: shift_result = shr[`ALU_WIDTH-1:0];
			2'd2: shift_result = sar[`ALU_WIDTH-1:0];
			default: shift_result = {2{32'hDEADBEEF}};
		endcase
	end

endmodule

//--- hdl/alu_mul.sv
// Pipelined 64 by 64 multiplier with a full 128-bit product
// A start pulse enters with the operands and leaves as mul_done
// after the last stage, so several products may overlap

`timescale 1ns/1ps

`include "alu_defs.svh"

module alu_mul (
	input  logic            clk,
	input  logic            rst,
	input  logic            mul_start,
	input  alu_pkg::func_t  func,
	input  alu_pkg::value_t a,
	input  alu_pkg::value_t b,
	input  alu_pkg::value_t imm,
	output alu_pkg::value_t prod_lo,
	output alu_pkg::value_t prod_hi,
	output logic            mul_done
);
	import alu_pkg::*;

	logic use_imm;
	logic sgn;
	value_t opb;
	double_value_t a_ext;
	double_value_t b_ext;
	double_value_t stage [`ALU_MUL_STAGES];
	logic [`ALU_MUL_STAGES-1:0] vld;

	// Operand select, any func outside the multiply group means an immediate multiply
	always_comb
	begin
		use_imm = !(func inside {FN_MUL, FN_MULU, FN_MULH, FN_MULUH});
		sgn     = !(func inside {FN_MULU, FN_MULUH});
		opb     = use_imm ? imm : b;
		// Sign extension to the product width makes one multiplier serve both kinds
		a_ext = {{`ALU_WIDTH{sgn & a[`ALU_WIDTH-1]}}, a};
		b_ext = {{`ALU_WIDTH{sgn & opb[`ALU_WIDTH-1]}}, opb};
	end

	// Product and its copies move one stage per clock
	always_ff @(posedge clk)
	begin
		stage[0] <= a_ext * b_ext;
		for (int i = 1; i < `ALU_MUL_STAGES; i++)
			stage[i] <= stage[i-1];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			vld <= '0;
		else
			vld <= {vld[`ALU_MUL_STAGES-2:0], mul_start};
	end

	assign prod_lo  = stage[`ALU_MUL_STAGES-1][`ALU_WIDTH-1:0];
	assign prod_hi  = stage[`ALU_MUL_STAGES-1][2*`ALU_WIDTH-1:`ALU_WIDTH];
	assign mul_done = vld[`ALU_MUL_STAGES-1];

endmodule

//--- hdl/alu_div.sv
// Radix-2 restoring divider, signed or unsigned
// Works on magnitudes and fixes the signs in a last cycle
// Quotient, remainder and div_dbz stay valid after the div_done pulse

`timescale 1ns/1ps

`include "alu_defs.svh"

module alu_div (
	input  logic            clk,
	input  logic            rst,
	input  logic            div_start,
	input  logic            div_signed,
	input  alu_pkg::value_t a,
	input  alu_pkg::value_t b,
	output alu_pkg::value_t quotient,
	output alu_pkg::value_t remainder,
	output logic            div_dbz,
	output logic            div_done
);
	import alu_pkg::*;

	logic busy;
	logic fix;
	logic zero;
	logic [`ALU_DIV_CNT_WIDTH-1:0] cnt;
	logic a_neg;
	logic b_neg;
	logic q_neg;
	logic r_neg;
	value_t a_mag;
	value_t b_mag;
	value_t q;
	value_t r;
	value_t dvs;
	logic [`ALU_WIDTH:0] r_shift;
	logic [`ALU_WIDTH:0] trial;

	always_comb
	begin
		a_neg = div_signed & a[`ALU_WIDTH-1];
		b_neg = div_signed & b[`ALU_WIDTH-1];
		a_mag = a_neg ? -a : a;
		b_mag = b_neg ? -b : b;
		// Next dividend bit moves into the partial remainder
		r_shift = {r, q[`ALU_WIDTH-1]};
		// Top bit set means the divisor did not fit
		trial = r_shift - {1'b0, dvs};
	end

	// ========================================
	// Sequencing
	// ========================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy     <= 1'b0;
			fix      <= 1'b0;
			zero     <= 1'b0;
			cnt      <= '0;
			div_done <= 1'b0;
			div_dbz  <= 1'b0;
		end
		else
		begin
			div_done <= 1'b0;
			fix      <= 1'b0;
			zero     <= 1'b0;
			if (div_start)
			begin
				if (b == '0)
					zero <= 1'b1;
				else
				begin
					busy <= 1'b1;
					cnt  <= `ALU_DIV_CNT_WIDTH'(`ALU_WIDTH);
				end
			end
			else if (busy)
			begin
				cnt <= cnt - 1'b1;
				if (cnt == `ALU_DIV_CNT_WIDTH'(1))
				begin
					busy <= 1'b0;
					fix  <= 1'b1;
				end
			end
			if (fix || zero)
			begin
				div_done <= 1'b1;
				div_dbz  <= zero;
			end
		end
	end

	// ========================================
	// Datapath
	// ========================================

	always_ff @(posedge clk)
	begin
		if (div_start)
		begin
			// A zero divisor keeps the raw dividend for the remainder
			q     <= (b == '0) ? a : a_mag;
			r     <= '0;
			dvs   <= b_mag;
			q_neg <= a_neg ^ b_neg;
			r_neg <= a_neg;
		end
		else if (busy)
		begin
			if (!trial[`ALU_WIDTH])
			begin
				r <= trial[`ALU_WIDTH-1:0];
				q <= {q[`ALU_WIDTH-2:0], 1'b1};
			end
			else
			begin
				r <= r_shift[`ALU_WIDTH-1:0];
				q <= {q[`ALU_WIDTH-2:0], 1'b0};
			end
		end
		if (fix)
		begin
			quotient  <= q_neg ? -q : q;
			// Remainder follows the sign of the dividend
			remainder <= r_neg ? -r : r;
		end
		else if (zero)
		begin
			quotient  <= '1;
			remainder <= q;
		end
	end

endmodule

//--- hdl/alu_ctrl.sv
// Sequencer of the execute unit
// Accepts one operation, starts the multiplier or divider when needed,
// and keeps the chosen result registered until the consumer takes it

`timescale 1ns/1ps

module alu_ctrl (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	output logic             in_ready,
	input  alu_pkg::opcode_t op,
	input  alu_pkg::func_t   func,
	output logic             out_valid,
	input  logic             out_ready,
	input  alu_pkg::value_t  logic_result,
	input  alu_pkg::value_t  shift_result,
	input  alu_pkg::value_t  prod_lo,
	input  alu_pkg::value_t  prod_hi,
	input  logic             mul_done,
	input  alu_pkg::value_t  quotient,
	input  alu_pkg::value_t  remainder,
	input  logic             div_dbz,
	input  logic             div_done,
	output logic             mul_start,
	output logic             div_start,
	output logic             div_signed,
	output alu_pkg::value_t  result,
	output logic             dbz
);
	import alu_pkg::*;

	alu_state_t state;
	logic accept;
	logic is_mul;
	logic is_div;
	logic want_hi;
	// Set when the multiply returns the high word or the divide the remainder
	logic upper_sel;

	// ========================================
	// Decode of the offered operation
	// ========================================

	always_comb
	begin
		is_mul = (op == OP_MULI) ||
			((op == OP_R2) && (func inside {FN_MUL, FN_MULU, FN_MULH, FN_MULUH}));
		is_div = (op == OP_DIVI) ||
			((op == OP_R2) && (func inside {FN_DIV, FN_DIVU, FN_MOD, FN_MODU}));
		// Only the register forms can ask for the upper word
		want_hi = (op == OP_R2) &&
			(func inside {FN_MULH, FN_MULUH, FN_MOD, FN_MODU});
		// The immediate divide is always signed
		div_signed = (op == OP_DIVI) ||
			((op == OP_R2) && (func inside {FN_DIV, FN_MOD}));
	end

	// A new operation is taken only when nothing is in flight or held
	assign in_ready  = (state == ST_IDLE);
	assign accept    = in_valid && in_ready;
	assign out_valid = (state == ST_HOLD);

	// Start pulses fall in the accept cycle so the units sample the live operands
	assign mul_start = accept && is_mul;
	assign div_start = accept && is_div;

	// ========================================
	// State machine
	// ========================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (accept)
					begin
						if (is_mul)
							state <= ST_MUL;
						else if (is_div)
							state <= ST_DIV;
						else
							state <= ST_HOLD;
					end
				end
				ST_MUL:
				begin
					if (mul_done)
						state <= ST_HOLD;
				end
				ST_DIV:
				begin
					if (div_done)
						state <= ST_HOLD;
				end
				default:
				begin
					// Leave only once the consumer has taken the result
					if (out_ready)
						state <= ST_IDLE;
				end
			endcase
		end
	end

	// Result register, loaded once per operation and frozen while held
	always_ff @(posedge clk)
	begin
		if ((state == ST_IDLE) && accept)
		begin
			upper_sel <= want_hi;
			if (!is_mul && !is_div)
			begin
				result <= (op == OP_SHIFT) ? shift_result : logic_result;
				dbz    <= 1'b0;
			end
		end
		else if ((state == ST_MUL) && mul_done)
		begin
			result <= upper_sel ? prod_hi : prod_lo;
			dbz    <= 1'b0;
		end
		else if ((state == ST_DIV) && div_done)
		begin
			result <= upper_sel ? remainder : quotient;
			dbz    <= div_dbz;
		end
	end

endmodule

//--- hdl/alu_top.sv
// Integer execute unit top level
// One operation in over a valid/ready pair, one result out over another

`timescale 1ns/1ps

module alu_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	output logic             in_ready,
	input  alu_pkg::opcode_t op,
	input  alu_pkg::func_t   func,
	input  alu_pkg::carry_t  carry,
	input  alu_pkg::cmod_t   cmod,
	input  alu_pkg::value_t  a,
	input  alu_pkg::value_t  b,
	input  alu_pkg::value_t  c,
	input  alu_pkg::value_t  imm,
	output logic             out_valid,
	input  logic             out_ready,
	output alu_pkg::value_t  result,
	output logic             dbz
);
	import alu_pkg::*;

	value_t logic_result;
	value_t shift_result;
	value_t prod_lo;
	value_t prod_hi;
	value_t quotient;
	value_t remainder;
	value_t div_b;
	logic mul_start;
	logic mul_done;
	logic div_start;
	logic div_signed;
	logic div_done;
	logic div_dbz;

	// The immediate divide takes its divisor from imm
	assign div_b = (op == OP_DIVI) ? imm : b;

	alu_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.in_valid(in_valid), .in_ready(in_ready), .op(op), .func(func),
		.out_valid(out_valid), .out_ready(out_ready),
		.logic_result(logic_result), .shift_result(shift_result),
		.prod_lo(prod_lo), .prod_hi(prod_hi), .mul_done(mul_done),
		.quotient(quotient), .remainder(remainder),
		.div_dbz(div_dbz), .div_done(div_done),
		.mul_start(mul_start), .div_start(div_start), .div_signed(div_signed),
		.result(result), .dbz(dbz)
	);

	alu_logic u_logic (
		.op(op), .func(func), .carry(carry), .cmod(cmod),
		.a(a), .b(b), .c(c), .imm(imm), .logic_result(logic_result)
	);

	alu_shift u_shift (.func(func), .a(a), .b(b), .c(c), .shift_result(shift_result));

	alu_mul u_mul (
		.clk(clk), .rst(rst), .mul_start(mul_start), .func(func),
		.a(a), .b(b), .imm(imm),
		.prod_lo(prod_lo), .prod_hi(prod_hi), .mul_done(mul_done)
	);

	alu_div u_div (
		.clk(clk), .rst(rst), .div_start(div_start), .div_signed(div_signed),
		.a(a), .b(div_b),
		.quotient(quotient), .remainder(remainder),
		.div_dbz(div_dbz), .div_done(div_done)
	);

endmodule

//--- verification/alu_tb.sv
// Testbench for the integer execute unit
// Reads one operation and its expected result per line from the pattern file,
// feeds them in order over the input handshake and checks every handoff
// while the output side is stalled at random

`timescale 1ns/1ps

module alu_tb;
	import alu_pkg::*;

	localparam int MAX_TESTS = 64;
	localparam int CYCLES_PER_TEST = 200;
	localparam int RESET_CYCLES = 8;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	opcode_t op;
	func_t func;
	carry_t carry;
	cmod_t cmod;
	value_t a;
	value_t b;
	value_t c;
	value_t imm;
	logic out_valid;
	logic out_ready;
	value_t result;
	logic dbz;

	// Pattern table, filled once before reset is released
	logic [8*24-1:0] names [0:MAX_TESTS-1];
	logic [3:0] op_q [0:MAX_TESTS-1];
	logic [4:0] func_q [0:MAX_TESTS-1];
	logic [1:0] carry_q [0:MAX_TESTS-1];
	logic [1:0] cmod_q [0:MAX_TESTS-1];
	value_t a_q [0:MAX_TESTS-1];
	value_t b_q [0:MAX_TESTS-1];
	value_t c_q [0:MAX_TESTS-1];
	value_t imm_q [0:MAX_TESTS-1];
	value_t exp_q [0:MAX_TESTS-1];
	logic dbz_q [0:MAX_TESTS-1];

	int num_tests;
	int got;
	int passes;
	int fails;
	int fd;
	int code;
	logic loaded;
	logic load_error;
	logic more;
	logic [8*24-1:0] tok;
	logic [8*256-1:0] skip;
	logic [3:0] rd_op;
	logic [4:0] rd_func;
	logic [1:0] rd_carry;
	logic [1:0] rd_cmod;
	value_t rd_a;
	value_t rd_b;
	value_t rd_c;
	value_t rd_imm;
	value_t rd_exp;
	logic rd_dbz;
	// Output seen on the last edge while the consumer stalled it
	logic stalled;
	value_t held_result;
	logic held_dbz;
	integer seed = 32'hd01c2d87;

	alu_top DUT (
		.clk(clk), .rst(rst),
		.in_valid(in_valid), .in_ready(in_ready),
		.op(op), .func(func), .carry(carry), .cmod(cmod),
		.a(a), .b(b), .c(c), .imm(imm),
		.out_valid(out_valid), .out_ready(out_ready),
		.result(result), .dbz(dbz)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// Compare one handoff with the next pattern line in sequence
	task automatic check_result();
		logic ok;
		ok = 1'b1;
		if (result !== exp_q[got])
		begin
			$display("CHECK FAILED %0s result expected %h actual %h",
				names[got], exp_q[got], result);
			ok = 1'b0;
		end
		if (dbz !== dbz_q[got])
		begin
			$display("CHECK FAILED %0s dbz expected %b actual %b",
				names[got], dbz_q[got], dbz);
			ok = 1'b0;
		end
		if (ok)
		begin
			$display("pass  %0s  result %h dbz %b", names[got], result, dbz);
			passes++;
		end
		else
			fails++;
		got++;
	endtask

	// ========================================
	// Receiver with random back-pressure
	// ========================================

	// Handshake values are read as they stood before the edge
	always @(posedge clk)
	begin
		if (rst)
		begin
			out_ready <= 1'b0;
			stalled = 1'b0;
		end
		else
		begin
			// Only one operation is in flight, so nothing new is taken while a result waits
			if (out_valid && in_ready)
			begin
				$display("in_ready was high while a result was waiting to be taken");
				fails++;
			end
			// A stalled result has to stay offered and unchanged
			if (stalled && !out_valid)
			begin
				$display("out_valid fell before the stalled result was taken");
				fails++;
			end
			else if (stalled && ((result !== held_result) || (dbz !== held_dbz)))
			begin
				$display("CHECK FAILED %0s held result expected %h dbz %b actual %h dbz %b",
					names[got], held_result, held_dbz, result, dbz);
				fails++;
			end
			if (out_valid && out_ready)
			begin
				if (got >= num_tests)
				begin
					$display("A result arrived with no pattern left to match it");
					fails++;
				end
				else
					check_result();
			end
			stalled = out_valid && !out_ready;
			held_result = result;
			held_dbz = dbz;
			// Ready about three cycles in four
			out_ready <= (($random(seed) & 3) != 0);
		end
	end

	// ========================================
	// Pattern load and driver
	// ========================================

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		op = OP_R2;
		func = FN_ADD;
		carry = '0;
		cmod = '0;
		a = '0;
		b = '0;
		c = '0;
		imm = '0;
		out_ready = 1'b0;
		stalled = 1'b0;
		num_tests = 0;
		got = 0;
		passes = 0;
		fails = 0;
		loaded = 1'b0;
		load_error = 1'b0;
		fd = $fopen("verification/alu_patterns.txt", "r");
		if (fd == 0)
			load_error = 1'b1;
		else
		begin
			more = 1'b1;
			while (more)
			begin
				code = $fscanf(fd, " %s", tok);
				if (code != 1)
					more = 1'b0;
				else if (tok == "//")
					code = $fgets(skip, fd);
				else
				begin
					code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h", rd_op, rd_func,
						rd_carry, rd_cmod, rd_a, rd_b, rd_c, rd_imm, rd_exp, rd_dbz);
					if ((code != 10) || (num_tests >= MAX_TESTS))
					begin
						$display("Pattern line %0d could not be read", num_tests + 1);
						load_error = 1'b1;
						more = 1'b0;
					end
					else
					begin
						names[num_tests] = tok;
						op_q[num_tests] = rd_op;
						func_q[num_tests] = rd_func;
						carry_q[num_tests] = rd_carry;
						cmod_q[num_tests] = rd_cmod;
						a_q[num_tests] = rd_a;
						b_q[num_tests] = rd_b;
						c_q[num_tests] = rd_c;
						imm_q[num_tests] = rd_imm;
						exp_q[num_tests] = rd_exp;
						dbz_q[num_tests] = rd_dbz;
						num_tests++;
					end
				end
			end
			$fclose(fd);
		end

		if (load_error || (num_tests == 0))
		begin
			$display("The pattern file is missing, empty or malformed");
			$display("TEST FAILED");
			$finish;
		end
		else
		begin
			loaded = 1'b1;
			repeat (RESET_CYCLES) @(posedge clk);
			rst <= 1'b0;
			for (int i = 0; i < num_tests; i++)
			begin
				// Payload stays put until the edge that takes it
				op <= opcode_t'(op_q[i]);
				func <= func_t'(func_q[i]);
				carry <= carry_q[i];
				cmod <= cmod_q[i];
				a <= a_q[i];
				b <= b_q[i];
				c <= c_q[i];
				imm <= imm_q[i];
				in_valid <= 1'b1;
				@(posedge clk);
				while (!in_ready)
					@(posedge clk);
			end
			in_valid <= 1'b0;
			wait (got == num_tests);
			// A few idle cycles catch a result delivered twice
			repeat (4) @(posedge clk);
			$display("Tests run %0d, passed %0d, failed %0d", num_tests, passes, fails);
			if ((fails == 0) && (passes == num_tests))
				$display("TEST PASSED");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

	// Watchdog sized from the number of pattern lines
	initial
	begin
		wait (loaded);
		repeat (RESET_CYCLES + num_tests * CYCLES_PER_TEST) @(posedge clk);
		$display("Timeout, result %0d of %0d never arrived", got + 1, num_tests);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verification/alu_patterns.txt
// name op func carry cmod a b c imm expected_result expected_dbz
// Every field after the name is hex, one test per line, results expected in this order
add_plain 0 00 0 0 7fffffffffffffff 1 0 0 8000000000000000 0
add_plus1_wrap 0 00 2 0 ffffffffffffffff 0 0 0 0 0
add_minus1 0 00 3 0 10 20 30 0 5f 0
add_zero 0 00 1 0 5 6 7 0 0 0
sub_plus1 0 01 3 0 100 30 20 0 b1 0
sub_minus1_wrap 0 01 2 0 0 0 0 0 ffffffffffffffff 0
and_cmod0 0 02 0 0 ff00ff00ff00ff00 f0f0f0f0f0f0f0f0 f000 0 f000f000f0000000 0
or_cmod1 0 03 0 1 1 0 10 0 fffffffffffffff1 0
eor_cmod2 0 04 0 2 ff00ff00ff00ff00 f0f0f0f0f0f0f0f0 0 0 f00ff00ff00ff00f 0
andc_cmod3 0 05 0 3 ffffffffffffffff ff 0 0 7fffffffffffff00 0
nand_cmod0 0 06 0 0 ff00ff00ff00ff00 f0f0f0f0f0f0f0f0 0 0 0fff0fff0fff0fff 0
seq_ones 0 0a 0 0 ffffffffffffffff ffffffffffffffff 0 0 1 0
slt_neg 0 0c 0 0 ffffffffffffffff 0 0 0 1 0
sltu_ones 0 0e 0 0 ffffffffffffffff 0 0 0 0 0
sle_equal 0 0d 0 0 8000000000000000 8000000000000000 0 0 1 0
max3_signed 0 10 0 0 ffffffffffffffff 5 8000000000000000 0 5 0
minu3_unsigned 0 14 0 0 ffffffffffffffff 5 8000000000000000 0 5 0
mid3_signed 0 12 0 0 ffffffffffffffff 5 8000000000000000 0 ffffffffffffffff 0
midu3_unsigned 0 15 0 0 ffffffffffffffff 5 8000000000000000 0 8000000000000000 0
addi_wrap 1 00 0 0 fffffffffffffffe 0 0 3 1 0
andi_mask 2 00 0 0 123456789abcdef0 0 0 ff f0 0
slti_neg 5 00 0 0 8000000000000000 0 0 0 1 0
mov_a 9 00 0 0 0123456789abcdef 0 0 0 0123456789abcdef 0
asl_0 8 00 0 0 89abcdef01234567 fedcba9876543210 0 0 fedcba9876543210 0
asl_1 8 00 0 0 89abcdef01234567 fedcba9876543210 1 0 fdb97530eca86421 0
asl_63 8 00 0 0 89abcdef01234567 fedcba9876543210 3f 0 44d5e6f78091a2b3 0
lsr_0 8 01 0 0 89abcdef01234567 fedcba9876543210 0 0 89abcdef01234567 0
lsr_8 8 01 0 0 89abcdef01234567 fedcba9876543210 8 0 1089abcdef012345 0
asr_36 8 02 0 0 89abcdef01234567 fedcba9876543210 24 0 fffffffff89abcde 0
asr_63 8 02 0 0 89abcdef01234567 fedcba9876543210 3f 0 ffffffffffffffff 0
mul_lo 0 16 0 0 10 20 0 0 200 0
mulh_neg 0 18 0 0 ffffffffffffffff 2 0 0 ffffffffffffffff 0
mulh_min 0 18 0 0 8000000000000000 ffffffffffffffff 0 0 0 0
muluh_min 0 19 0 0 8000000000000000 ffffffffffffffff 0 0 7fffffffffffffff 0
muli_neg 6 00 0 0 fffffffffffffffd 0 0 7 ffffffffffffffeb 0
div_neg_pos 0 1a 0 0 ffffffffffffff9c 7 0 0 fffffffffffffff2 0
mod_neg_pos 0 1c 0 0 ffffffffffffff9c 7 0 0 fffffffffffffffe 0
mod_pos_neg 0 1c 0 0 64 fffffffffffffff9 0 0 2 0
divu_ones 0 1b 0 0 ffffffffffffffff 10 0 0 0fffffffffffffff 0
modu_ones 0 1d 0 0 ffffffffffffffff 10 0 0 f 0
div_zero 0 1a 0 0 1234 0 0 0 ffffffffffffffff 1
mod_zero 0 1c 0 0 ffffffffffffff9c 0 0 0 ffffffffffffff9c 1
divi_neg 7 00 0 0 ffffffffffffff9c 0 0 a fffffffffffffff6 0

//--- filelist.f
+incdir+hdl
hdl/alu_pkg.sv
hdl/alu_logic.sv
hdl/alu_shift.sv
hdl/alu_mul.sv
hdl/alu_div.sv
hdl/alu_ctrl.sv
hdl/alu_top.sv
verification/alu_tb.sv
